// File: bench/conn_manager_tb.sv
`default_nettype none
`timescale 1ns/1ps

module conn_manager_tb
    import table_pkg::*, net_pkg::*;
();

    localparam string VEC_FILE = "bench/conn_vectors.txt";
    // Longest control exchange plus some slack
    localparam int RESP_LIMIT = RAM_LATENCY + 2 + WAYS + 2;

    // One queued lookup with its request fields and expected response
    typedef struct packed {
        logic [7:0] op;
        conn_id_t   id;
        logic       hit;
        ip_addr_t   ip;
        mac_addr_t  mac;
        udp_port_t  port;
    } lookup_t;

    logic      clk;
    logic      rst;
    logic      fw_req_valid;
    ip_addr_t  fw_req_ip;
    logic      fw_resp_valid;
    logic      fw_resp_hit;
    conn_id_t  fw_resp_conn_id;
    logic      rv_req_valid;
    conn_id_t  rv_req_conn_id;
    logic      rv_resp_valid;
    logic      rv_resp_hit;
    ip_addr_t  rv_resp_ip;
    mac_addr_t rv_resp_mac;
    udp_port_t rv_resp_port;
    logic      cmd_valid;
    logic      cmd_bind;
    ip_addr_t  cmd_ip;
    mac_addr_t cmd_mac;
    udp_port_t cmd_port;
    logic      cmd_ready;
    logic      resp_valid;
    logic      resp_ack;
    logic      resp_full;
    conn_id_t  resp_conn_id;

    lookup_t burst [$];
    int      checks = 0;
    int      cycles = 0;
    int      cycle_limit = 0;

    tb_clock_gen clkgen (.clk(clk), .rst(rst));

    conn_manager_top uut (
        .clk(clk), .rst(rst),
        .fw_req_valid(fw_req_valid), .fw_req_ip(fw_req_ip),
        .fw_resp_valid(fw_resp_valid), .fw_resp_hit(fw_resp_hit),
        .fw_resp_conn_id(fw_resp_conn_id),
        .rv_req_valid(rv_req_valid), .rv_req_conn_id(rv_req_conn_id),
        .rv_resp_valid(rv_resp_valid), .rv_resp_hit(rv_resp_hit),
        .rv_resp_ip(rv_resp_ip), .rv_resp_mac(rv_resp_mac), .rv_resp_port(rv_resp_port),
        .cmd_valid(cmd_valid), .cmd_bind(cmd_bind), .cmd_ip(cmd_ip),
        .cmd_mac(cmd_mac), .cmd_port(cmd_port), .cmd_ready(cmd_ready),
        .resp_valid(resp_valid), .resp_ack(resp_ack), .resp_full(resp_full),
        .resp_conn_id(resp_conn_id)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Step to 1 ns past the next edge where inputs change and outputs are read
    task automatic next_step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        fw_req_valid   = 1'b0;
        fw_req_ip      = '0;
        rv_req_valid   = 1'b0;
        rv_req_conn_id = '0;
        cmd_valid      = 1'b0;
        cmd_bind       = 1'b0;
        cmd_ip         = '0;
        cmd_mac        = '0;
        cmd_port       = '0;
    endtask

    // ------------------------------------------------------------------
    // Control command and its response pulse
    // ------------------------------------------------------------------

    task automatic run_command(input logic is_bind, input ip_addr_t ip, input mac_addr_t mac,
                               input udp_port_t port, input logic exp_ack,
                               input logic exp_full, input conn_id_t exp_id);
        int waited;
        waited = 0;
        check_value("cmd_ready", cmd_ready, 1'b1);
        cmd_valid = 1'b1;
        cmd_bind  = is_bind;
        cmd_ip    = ip;
        cmd_mac   = mac;
        cmd_port  = port;
        next_step();
        cmd_valid = 1'b0;
        // Busy from acceptance until the pulse
        while (resp_valid !== 1'b1) begin
            if (waited >= RESP_LIMIT) begin
                fail_run($sformatf("No control response within %0d cycles for ip %h",
                                   RESP_LIMIT, ip));
            end
            check_value("cmd_ready", cmd_ready, 1'b0);
            next_step();
            waited++;
        end
        check_value("cmd_ready", cmd_ready, 1'b0);
        check_value("resp_ack", resp_ack, exp_ack);
        check_value("resp_full", resp_full, exp_full);
        // Only a bind that succeeds hands out an id
        if (is_bind && exp_ack) begin
            check_value("resp_conn_id", resp_conn_id, exp_id);
        end
        next_step();
        check_value("resp_valid", resp_valid, 1'b0);
        check_value("cmd_ready", cmd_ready, 1'b1);
    endtask

    // ------------------------------------------------------------------
    // Lookup burst with one request per cycle
    // ------------------------------------------------------------------

    task automatic flush_lookups();
        int      n;
        int      j;
        lookup_t req;
        lookup_t exp;
        n = burst.size();
        for (int k = 0; k < n + RAM_LATENCY; k++) begin
            j = k - RAM_LATENCY;
            // Response of the request issued RAM_LATENCY steps ago
            if (j >= 0) begin
                exp = burst[j];
                check_value("fw_resp_valid", fw_resp_valid, exp.op == "F");
                check_value("rv_resp_valid", rv_resp_valid, exp.op == "R");
                if (exp.op == "F") begin
                    check_value("fw_resp_hit", fw_resp_hit, exp.hit);
                    if (exp.hit) begin
                        check_value("fw_resp_conn_id", fw_resp_conn_id, exp.id);
                    end
                end else if (exp.hit) begin
                    check_value("rv_resp_hit", rv_resp_hit, 1'b1);
                    check_value("rv_resp_ip", rv_resp_ip, exp.ip);
                    check_value("rv_resp_mac", rv_resp_mac, exp.mac);
                    check_value("rv_resp_port", rv_resp_port, exp.port);
                end else begin
                    check_value("rv_resp_hit", rv_resp_hit, 1'b0);
                end
            end else begin
                check_value("fw_resp_valid", fw_resp_valid, 1'b0);
                check_value("rv_resp_valid", rv_resp_valid, 1'b0);
            end
            fw_req_valid = 1'b0;
            rv_req_valid = 1'b0;
            if (k < n) begin
                req = burst[k];
                if (req.op == "F") begin
                    fw_req_valid = 1'b1;
                    fw_req_ip    = req.ip;
                end else begin
                    rv_req_valid   = 1'b1;
                    rv_req_conn_id = req.id;
                end
            end
            next_step();
        end
        burst.delete();
    endtask

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int                fd;
        int                code;
        int                n_lines;
        logic              done;
        logic [7:0]        op;
        logic [8*256-1:0]  line;
        ip_addr_t          ip;
        mac_addr_t         mac;
        udp_port_t         port;
        conn_id_t          id;
        logic              ack;
        logic              full;
        logic              hit;
        lookup_t           item;

        idle_inputs();

        // Size the watchdog from the vector count
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            fail_run({"Cannot open vector file ", VEC_FILE});
        end
        n_lines = 0;
        while ($fgets(line, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        cycle_limit = 20 * n_lines + 50;

        // Quiet and ready straight out of reset
        wait (rst === 1'b0);
        for (int i = 0; i < 3; i++) begin
            check_value("cmd_ready", cmd_ready, 1'b1);
            check_value("resp_valid", resp_valid, 1'b0);
            check_value("fw_resp_valid", fw_resp_valid, 1'b0);
            check_value("rv_resp_valid", rv_resp_valid, 1'b0);
            next_step();
        end

        fd   = $fopen(VEC_FILE, "r");
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (op)
                    "#": code = $fgets(line, fd);
                    // Pending lookups go out before the table changes
                    "B": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h", ip, mac, port, ack, full, id);
                        flush_lookups();
                        run_command(1'b1, ip, mac, port, ack, full, id);
                    end
                    "U": begin
                        code = $fscanf(fd, "%h %h", ip, ack);
                        flush_lookups();
                        run_command(1'b0, ip, '0, '0, ack, 1'b0, '0);
                    end
                    "F": begin
                        code = $fscanf(fd, "%h %h %h", ip, hit, id);
                        item     = '0;
                        item.op  = op;
                        item.ip  = ip;
                        item.hit = hit;
                        item.id  = id;
                        burst.push_back(item);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h %h %h", id, hit, ip, mac, port);
                        item      = '0;
                        item.op   = op;
                        item.id   = id;
                        item.hit  = hit;
                        item.ip   = ip;
                        item.mac  = mac;
                        item.port = port;
                        burst.push_back(item);
                    end
                    default: fail_run($sformatf("Unknown op '%c' in vector file", op));
                endcase
            end
        end
        $fclose(fd);
        flush_lookups();

        next_step();
        $display("%0d checks done", checks);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/conn_vectors.txt
# B ip mac port ack full id | U ip ack | F ip hit id | R id hit ip mac port
# All hex, id is way (2 bits) over hash (8 bits), hash is the XOR of the ip bytes
B 0a000001 020000000001 1f41 1 0 00b
B 0b000000 020000000002 1f42 1 0 10b
B 0a000001 020000000001 1f41 1 0 00b
B 0000000b 020000000003 1f43 1 0 20b
B 0a010000 020000000004 1f44 1 0 30b
B 0001000a 020000000005 1f45 0 1 000
B c0a80101 0200000000a0 0035 1 0 068
F 0a000001 1 00b
F 0b000000 1 10b
F c0a80102 0 000
F c0a80101 1 068
R 00b 1 0a000001 020000000001 1f41
R 30b 1 0a010000 020000000004 1f44
R 168 0 00000000 000000000000 0000
F 0001000a 0 000
U 0b000000 1
F 0b000000 0 000
R 10b 0 00000000 000000000000 0000
F 0a000001 1 00b
U c0a80102 0
B 0001000a 020000000005 1f45 1 0 10b
F 0001000a 1 10b
R 10b 1 0001000a 020000000005 1f45
R 20b 1 0000000b 020000000003 1f43
U 0a000001 1
U 0a000001 0
R 00b 0 00000000 000000000000 0000
F 0a000001 0 000

// File: bench/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // Free running clock, 10 ns period with the defaults
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held over the first rising edges, released just after one
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: build.f
src/table_pkg.sv
src/net_pkg.sv
src/way_ram.sv
src/fw_lookup.sv
src/rv_lookup.sv
src/conn_ctrl_fsm.sv
src/conn_manager_top.sv
bench/tb_clock_gen.sv
bench/conn_manager_tb.sv

// File: src/conn_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module conn_ctrl_fsm
    import table_pkg::*, net_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Command, taken when cmd_valid and cmd_ready are both high
    input  logic        cmd_valid,
    input  logic        cmd_bind,
    input  ip_addr_t    cmd_ip,
    input  mac_addr_t   cmd_mac,
    input  udp_port_t   cmd_port,
    output logic        cmd_ready,
    // Port A of every way memory
    output hash_t       wr_addr,
    output logic [WAYS-1:0] wr_en,
    output tag_entry_t  wr_tag,
    output conn_entry_t wr_entry,
    input  tag_entry_t  tag_rd [WAYS],
    // Response pulse
    output logic        resp_valid,
    output logic        resp_ack,
    output logic        resp_full,
    output conn_id_t    resp_conn_id
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_WAIT,
        ST_CHECK,
        ST_ALLOC,
        ST_RELEASE
    } state_t;

    state_t state;

    // Latched command
    logic      bind_q;
    ip_addr_t  ip_q;
    mac_addr_t mac_q;
    udp_port_t port_q;
    hash_t     hash_q;

    // Read wait counter and allocation scan pointer
    logic [$clog2(RAM_LATENCY+1)-1:0] wait_cnt;
    way_t way_iter;

    // Tag compare results, sampled once in ST_CHECK
    logic [WAYS-1:0] match;
    logic [WAYS-1:0] match_q;
    way_t            match_way;
    way_t            match_way_q;

    logic cmd_take;
    logic free_now;
    logic alloc_done;

    // Idle and not still showing the previous response
    assign cmd_ready = (state == ST_IDLE) && !resp_valid;
    assign cmd_take  = cmd_valid && cmd_ready;

    // ------------------------------------------------------------------
    // Set compare
    // ------------------------------------------------------------------

    // Port A keeps reading hash_q so the set stays on tag_rd until the write
    always_comb begin
        match     = '0;
        match_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (tag_rd[w].valid && tag_rd[w].ip == ip_q) begin
                match[w]  = 1'b1;
                match_way = way_t'(w);
            end
        end
    end

    // Scan step, ways are tried from 0 up
    assign free_now   = !tag_rd[way_iter].valid;
    assign alloc_done = (match_q != '0) || free_now || (way_iter == way_t'(WAYS-1));

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------

    // Same address and data to all ways, wr_en picks the target
    assign wr_addr  = hash_q;
    assign wr_tag   = '{valid: (state == ST_ALLOC), ip: ip_q};
    assign wr_entry = '{valid: (state == ST_ALLOC), ip: ip_q, mac: mac_q, port: port_q};

    // Write fires on the same edge that raises resp_valid
    always_comb begin
        wr_en = '0;
        if (state == ST_RELEASE) begin
            wr_en = match_q;
        end else if (state == ST_ALLOC && match_q == '0 && free_now) begin
            wr_en[way_iter] = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            resp_valid <= 1'b0;
            wait_cnt   <= '0;
            way_iter   <= '0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_take) begin
                        wait_cnt <= '0;
                        state    <= ST_READ_WAIT;
                    end
                end
                // Address is stable, wait out the read latency
                ST_READ_WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == RAM_LATENCY-1) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    way_iter <= '0;
                    state    <= bind_q ? ST_ALLOC : ST_RELEASE;
                end
                // One way per cycle until a hit, a free way or the last way
                ST_ALLOC: begin
                    if (alloc_done) begin
                        resp_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end else begin
                        way_iter <= way_iter + 1'b1;
                    end
                end
                ST_RELEASE: begin
                    resp_valid <= 1'b1;
                    state      <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Command and response payload
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            bind_q <= cmd_bind;
            ip_q   <= cmd_ip;
            mac_q  <= cmd_mac;
            port_q <= cmd_port;
            hash_q <= ip_hash(cmd_ip);
        end
        if (state == ST_CHECK) begin
            match_q     <= match;
            match_way_q <= match_way;
        end
        if (state == ST_ALLOC && alloc_done) begin
            if (match_q != '0) begin
                // Already bound, hand back the old id
                resp_ack     <= 1'b1;
                resp_full    <= 1'b0;
                resp_conn_id <= {match_way_q, hash_q};
            end else if (free_now) begin
                resp_ack     <= 1'b1;
                resp_full    <= 1'b0;
                resp_conn_id <= {way_iter, hash_q};
            end else begin
                // Every way of the set is taken
                resp_ack     <= 1'b0;
                resp_full    <= 1'b1;
                resp_conn_id <= '0;
            end
        end
        if (state == ST_RELEASE) begin
            resp_ack     <= (match_q != '0);
            resp_full    <= 1'b0;
            resp_conn_id <= {match_way_q, hash_q};
        end
    end

endmodule

`default_nettype wire

// File: src/conn_manager_top.sv
`default_nettype none
`timescale 1ns/1ps

module conn_manager_top
    import table_pkg::*, net_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Forward lookup
    input  logic      fw_req_valid,
    input  ip_addr_t  fw_req_ip,
    output logic      fw_resp_valid,
    output logic      fw_resp_hit,
    output conn_id_t  fw_resp_conn_id,
    // Reverse lookup
    input  logic      rv_req_valid,
    input  conn_id_t  rv_req_conn_id,
    output logic      rv_resp_valid,
    output logic      rv_resp_hit,
    output ip_addr_t  rv_resp_ip,
    output mac_addr_t rv_resp_mac,
    output udp_port_t rv_resp_port,
    // Bind and unbind commands
    input  logic      cmd_valid,
    input  logic      cmd_bind,
    input  ip_addr_t  cmd_ip,
    input  mac_addr_t cmd_mac,
    input  udp_port_t cmd_port,
    output logic      cmd_ready,
    output logic      resp_valid,
    output logic      resp_ack,
    output logic      resp_full,
    output conn_id_t  resp_conn_id
);

    // ------------------------------------------------------------------
    // Internal buses
    // ------------------------------------------------------------------

    // Control side, port A of every memory
    hash_t           wr_addr;
    logic [WAYS-1:0] wr_en;
    tag_entry_t      wr_tag;
    conn_entry_t     wr_entry;
    tag_entry_t      ctrl_tag [WAYS];

    // Lookup side, port B
    hash_t           fw_addr;
    tag_entry_t      fw_tag   [WAYS];
    hash_t           rv_addr;
    conn_entry_t     rv_entry [WAYS];

    // ------------------------------------------------------------------
    // Control FSM and lookup pipelines
    // ------------------------------------------------------------------

    conn_ctrl_fsm ctrl (
        .clk(clk), .rst(rst),
        .cmd_valid(cmd_valid), .cmd_bind(cmd_bind), .cmd_ip(cmd_ip),
        .cmd_mac(cmd_mac), .cmd_port(cmd_port), .cmd_ready(cmd_ready),
        .wr_addr(wr_addr), .wr_en(wr_en), .wr_tag(wr_tag), .wr_entry(wr_entry),
        .tag_rd(ctrl_tag),
        .resp_valid(resp_valid), .resp_ack(resp_ack), .resp_full(resp_full),
        .resp_conn_id(resp_conn_id)
    );

    fw_lookup fw (
        .clk(clk), .rst(rst),
        .fw_req_valid(fw_req_valid), .fw_req_ip(fw_req_ip),
        .tag_addr(fw_addr), .tag_rd(fw_tag),
        .fw_resp_valid(fw_resp_valid), .fw_resp_hit(fw_resp_hit),
        .fw_resp_conn_id(fw_resp_conn_id)
    );

    rv_lookup rv (
        .clk(clk), .rst(rst),
        .rv_req_valid(rv_req_valid), .rv_req_conn_id(rv_req_conn_id),
        .entry_addr(rv_addr), .entry_rd(rv_entry),
        .rv_resp_valid(rv_resp_valid), .rv_resp_hit(rv_resp_hit),
        .rv_resp_ip(rv_resp_ip), .rv_resp_mac(rv_resp_mac),
        .rv_resp_port(rv_resp_port)
    );

    // ------------------------------------------------------------------
    // Per-way memories
    // ------------------------------------------------------------------

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        // Tag store, searched by forward lookup and by the FSM
        way_ram #(.payload_t(tag_entry_t)) tag_ram (
            .clk(clk), .rst(rst),
            .a_we(wr_en[w]), .a_addr(wr_addr), .a_din(wr_tag), .a_dout(ctrl_tag[w]),
            .b_addr(fw_addr), .b_dout(fw_tag[w])
        );

        // Full record, only reverse lookup reads it back
        way_ram #(.payload_t(conn_entry_t)) entry_ram (
            .clk(clk), .rst(rst),
            .a_we(wr_en[w]), .a_addr(wr_addr), .a_din(wr_entry), .a_dout(),
            .b_addr(rv_addr), .b_dout(rv_entry[w])
        );
    end

endmodule

`default_nettype wire

// File: src/fw_lookup.sv
`default_nettype none
`timescale 1ns/1ps

module fw_lookup
    import table_pkg::*, net_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Request, one per cycle
    input  logic       fw_req_valid,
    input  ip_addr_t   fw_req_ip,
    // Tag store port B
    output hash_t      tag_addr,
    input  tag_entry_t tag_rd [WAYS],
    // Response, RAM_LATENCY cycles after the request
    output logic       fw_resp_valid,
    output logic       fw_resp_hit,
    output conn_id_t   fw_resp_conn_id
);

    // Request side copies that travel alongside the memory read
    logic     valid_pipe [RAM_LATENCY];
    ip_addr_t ip_pipe    [RAM_LATENCY];
    hash_t    hash_pipe  [RAM_LATENCY];

    // Set index straight from the request
    assign tag_addr = ip_hash(fw_req_ip);

    // ------------------------------------------------------------------
    // Delay line
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_LATENCY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= fw_req_valid;
            for (int i = 1; i < RAM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        ip_pipe[0]   <= fw_req_ip;
        hash_pipe[0] <= tag_addr;
        for (int i = 1; i < RAM_LATENCY; i++) begin
            ip_pipe[i]   <= ip_pipe[i-1];
            hash_pipe[i] <= hash_pipe[i-1];
        end
    end

    // ------------------------------------------------------------------
    // Tag compare
    // ------------------------------------------------------------------

    assign fw_resp_valid = valid_pipe[RAM_LATENCY-1];

    // At most one way holds a given IP, bind never duplicates it
    always_comb begin
        fw_resp_hit     = 1'b0;
        fw_resp_conn_id = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (tag_rd[w].valid && tag_rd[w].ip == ip_pipe[RAM_LATENCY-1]) begin
                fw_resp_hit     = 1'b1;
                fw_resp_conn_id = {way_t'(w), hash_pipe[RAM_LATENCY-1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/net_pkg.sv
`default_nettype none

package net_pkg;

    // ------------------------------------------------------------------
    // Network fields
    // ------------------------------------------------------------------

    typedef logic [31:0] ip_addr_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] udp_port_t;

    // ------------------------------------------------------------------
    // Stored entries
    // ------------------------------------------------------------------

    // Tag word, searched by forward lookup and by the control FSM
    typedef struct packed {
        logic     valid;
        ip_addr_t ip;
    } tag_entry_t;

    // Full endpoint record, returned by reverse lookup
    typedef struct packed {
        logic      valid;
        ip_addr_t  ip;
        mac_addr_t mac;
        udp_port_t port;
    } conn_entry_t;

endpackage

`default_nettype wire

// File: src/rv_lookup.sv
`default_nettype none
`timescale 1ns/1ps

module rv_lookup
    import table_pkg::*, net_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Request, one per cycle
    input  logic        rv_req_valid,
    input  conn_id_t    rv_req_conn_id,
    // Entry store port B
    output hash_t       entry_addr,
    input  conn_entry_t entry_rd [WAYS],
    // Response, RAM_LATENCY cycles after the request
    output logic        rv_resp_valid,
    output logic        rv_resp_hit,
    output ip_addr_t    rv_resp_ip,
    output mac_addr_t   rv_resp_mac,
    output udp_port_t   rv_resp_port
);

    logic        valid_pipe [RAM_LATENCY];
    way_t        way_pipe   [RAM_LATENCY];
    conn_entry_t sel;

    // Lower id bits pick the set
    assign entry_addr = rv_req_conn_id[HASH_WIDTH-1:0];

    // ------------------------------------------------------------------
    // Delay line
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_LATENCY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= rv_req_valid;
            for (int i = 1; i < RAM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Upper id bits pick the way once the set arrives
    always_ff @(posedge clk) begin
        way_pipe[0] <= rv_req_conn_id[WAY_BITS+HASH_WIDTH-1:HASH_WIDTH];
        for (int i = 1; i < RAM_LATENCY; i++) begin
            way_pipe[i] <= way_pipe[i-1];
        end
    end

    // ------------------------------------------------------------------
    // Way select
    // ------------------------------------------------------------------

    assign sel = entry_rd[way_pipe[RAM_LATENCY-1]];

    assign rv_resp_valid = valid_pipe[RAM_LATENCY-1];
    // An empty way reports a miss, its fields are don't care
    assign rv_resp_hit   = sel.valid;
    assign rv_resp_ip    = sel.ip;
    assign rv_resp_mac   = sel.mac;
    assign rv_resp_port  = sel.port;

endmodule

`default_nettype wire

// File: src/table_pkg.sv
`default_nettype none

package table_pkg;

    // ------------------------------------------------------------------
    // Table geometry
    // ------------------------------------------------------------------

    // Ways per index, a set behaves like a small cache set
    localparam int WAYS = 4;
    localparam int WAY_BITS = $clog2(WAYS);

    // Index bits and number of sets
    localparam int HASH_WIDTH = 8;
    localparam int INDEXES = 1 << HASH_WIDTH;

    // Read latency of both memory ports in clock cycles
    localparam int RAM_LATENCY = 2;

    // ------------------------------------------------------------------
    // Index and id types
    // ------------------------------------------------------------------

    typedef logic [HASH_WIDTH-1:0] hash_t;
    typedef logic [WAY_BITS-1:0] way_t;

    // Way number on top, set index below
    typedef logic [WAY_BITS+HASH_WIDTH-1:0] conn_id_t;

    // ------------------------------------------------------------------
    // Hash
    // ------------------------------------------------------------------

    // Fold the four address bytes into one set index
    function automatic hash_t ip_hash(input logic [31:0] ip);
        return ip[31:24] ^ ip[23:16] ^ ip[15:8] ^ ip[7:0];
    endfunction

endpackage

`default_nettype wire

// File: src/way_ram.sv
`default_nettype none
`timescale 1ns/1ps

module way_ram
    import table_pkg::*;
#(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    // Port A, read and write, belongs to the control FSM
    input  logic     a_we,
    input  hash_t    a_addr,
    input  payload_t a_din,
    output payload_t a_dout,
    // Port B, read only, belongs to a lookup pipeline
    input  hash_t    b_addr,
    output payload_t b_dout
);

    // Storage starts all zero so every valid bit is low
    payload_t mem [INDEXES] = '{default: '0};

    // Output register chains, RAM_LATENCY deep
    payload_t a_pipe [RAM_LATENCY];
    payload_t b_pipe [RAM_LATENCY];

    // Write port
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
    end

    // Read ports
    // A read during a write to the same word returns the old word
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RAM_LATENCY; i++) begin
                a_pipe[i] <= '0;
                b_pipe[i] <= '0;
            end
        end else begin
            a_pipe[0] <= mem[a_addr];
            b_pipe[0] <= mem[b_addr];
            for (int i = 1; i < RAM_LATENCY; i++) begin
                a_pipe[i] <= a_pipe[i-1];
                b_pipe[i] <= b_pipe[i-1];
            end
        end
    end

    assign a_dout = a_pipe[RAM_LATENCY-1];
    assign b_dout = b_pipe[RAM_LATENCY-1];

endmodule

`default_nettype wire
